//--- bench/exec_unit_tb.sv
`timescale 1ns/1ns
`include "alu_config.svh"

module exec_unit_tb;
    import alu_pkg::*;

    typedef struct {
        string   name;
        opcode_t op;
        funct_t  fn;
        shamt_t  sh;
        imm_t    imm;
        reg_t    rs;
        reg_t    rt;
        reg_t    res;
        logic    zero;
        logic    taken;
        logic    ill;
    } entry_t;

    typedef struct {
        string name;
        reg_t  res;
        logic  zero;
        logic  taken;
        logic  ill;
        int    cycle;       // Cycle count when the strobe was driven
    } expect_t;

    localparam int N_ENTRIES = 27;

    // name, opcode, funct, shamt, imm, rs, rt, result, zero, taken, illegal
    entry_t tbl [N_ENTRIES] = '{
        '{"addu", `OP_RTYPE, `FN_ADDU, 0, 'h0, 'h5, 'h7, 'hc, 0, 0, 0},
        '{"addu_wrap", `OP_RTYPE, `FN_ADDU, 0, 'h0, 'hffffffff, 'h1, 'h0, 1, 0, 0},
        '{"subu_neg", `OP_RTYPE, `FN_SUBU, 0, 'h0, 'h3, 'ha, 'hfffffff9, 0, 0, 0},
        '{"and", `OP_RTYPE, `FN_AND, 0, 'h0, 'hf0f01234, 'h0ff0ff00, 'h00f01200, 0, 0, 0},
        '{"or", `OP_RTYPE, `FN_OR, 0, 'h0, 'hf000000f, 'h0f0000f0, 'hff0000ff, 0, 0, 0},
        '{"xor", `OP_RTYPE, `FN_XOR, 0, 'h0, 'hffff0000, 'h0f0f0f0f, 'hf0f00f0f, 0, 0, 0},
        '{"nor", `OP_RTYPE, `FN_NOR, 0, 'h0, 'h0000ffff, 'h00ff0000, 'hff000000, 0, 0, 0},
        '{"slt_neg", `OP_RTYPE, `FN_SLT, 0, 'h0, 'hfffffffe, 'h1, 'h1, 0, 0, 0},
        '{"slt_false", `OP_RTYPE, `FN_SLT, 0, 'h0, 'h5, 'hffffffff, 'h0, 1, 0, 0},
        '{"addiu_neg", `OP_ADDIU, 0, 0, 'hfffd, 'ha, 'h0, 'h7, 0, 0, 0},
        '{"slti_neg", `OP_SLTI, 0, 0, 'hfff8, 'hfffffff0, 'h0, 'h1, 0, 0, 0},
        '{"andi_zext", `OP_ANDI, 0, 0, 'h8001, 'hffffffff, 'h0, 'h00008001, 0, 0, 0},
        '{"ori", `OP_ORI, 0, 0, 'habcd, 'h12340000, 'h0, 'h1234abcd, 0, 0, 0},
        '{"xori", `OP_XORI, 0, 0, 'hffff, 'hffffffff, 'h0, 'hffff0000, 0, 0, 0},
        '{"lui", `OP_LUI, 0, 0, 'hbeef, 'h1234, 'h0, 'hbeef0000, 0, 0, 0},
        '{"sll", `OP_RTYPE, `FN_SLL, 4, 'h0, 'h0, 'hf1, 'hf10, 0, 0, 0},
        '{"srl", `OP_RTYPE, `FN_SRL, 8, 'h0, 'h0, 'h80000000, 'h00800000, 0, 0, 0},
        '{"sra_neg", `OP_RTYPE, `FN_SRA, 4, 'h0, 'h0, 'h80000000, 'hf8000000, 0, 0, 0},
        '{"sllv_36", `OP_RTYPE, `FN_SLLV, 0, 'h0, 'h24, 'h1, 'h10, 0, 0, 0},
        '{"srlv_33", `OP_RTYPE, `FN_SRLV, 0, 'h0, 'h21, 'h80000000, 'h40000000, 0, 0, 0},
        '{"srav_neg", `OP_RTYPE, `FN_SRAV, 0, 'h0, 'hffffffe4, 'hf0000000, 'hff000000, 0, 0, 0},
        '{"beq_eq", `OP_BEQ, 0, 0, 'h0, 'h55, 'h55, 'h0, 1, 1, 0},
        '{"bne_eq", `OP_BNE, 0, 0, 'h0, 'h55, 'h55, 'h1, 0, 0, 0},
        '{"beq_ne", `OP_BEQ, 0, 0, 'h0, 'h1, 'h2, 'h1, 0, 0, 0},
        '{"bne_ne", `OP_BNE, 0, 0, 'h0, 'h1, 'h2, 'h0, 1, 1, 0},
        '{"bad_funct", `OP_RTYPE, 'h3f, 0, 'h0, 'h7, 'h9, 'h0, 1, 0, 1},
        '{"bad_opcode", 'h23, 0, 0, 'h1234, 'h7, 'h9, 'h0, 1, 0, 1}
    };

    logic    clk = 1'b0;
    logic    i_rst;
    logic    i_valid;
    opcode_t i_opcode;
    funct_t  i_funct;
    shamt_t  i_shamt;
    imm_t    i_imm;
    reg_t    i_rs_data;
    reg_t    i_rt_data;
    logic    o_valid;
    reg_t    o_result;
    logic    o_zero;
    logic    o_branch_taken;
    logic    o_illegal;

    expect_t exp_q [$];                 // Results still in the pipeline
    integer  seed    = 32'hc4c8;
    int      cycle   = 0;

    exec_unit dut_i (
        .i_clk          (clk),
        .i_rst          (i_rst),
        .i_valid        (i_valid),
        .i_opcode       (i_opcode),
        .i_funct        (i_funct),
        .i_shamt        (i_shamt),
        .i_imm          (i_imm),
        .i_rs_data      (i_rs_data),
        .i_rt_data      (i_rt_data),
        .o_valid        (o_valid),
        .o_result       (o_result),
        .o_zero         (o_zero),
        .o_branch_taken (o_branch_taken),
        .o_illegal      (o_illegal)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input string what, input reg_t exp,
                               input reg_t act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", name, what, exp, act);
            abort_run();
        end
    endtask

    // Expected outcome worked out from the instruction set rules
    function automatic expect_t model(input entry_t e);
        expect_t x;
        reg_t    sext;
        reg_t    zext;
        sext    = {{16{e.imm[15]}}, e.imm};
        zext    = {16'h0000, e.imm};
        x.name  = e.name;
        x.res   = '0;
        x.taken = 1'b0;
        x.ill   = 1'b0;
        x.cycle = 0;
        case (e.op)
            `OP_RTYPE: begin
                case (e.fn)
                    `FN_SLL:  x.res = e.rt << e.sh;
                    `FN_SRL:  x.res = e.rt >> e.sh;
                    `FN_SRA:  x.res = e.rt >>> e.sh;
                    `FN_SLLV: x.res = e.rt << e.rs[4:0];
                    `FN_SRLV: x.res = e.rt >> e.rs[4:0];
                    `FN_SRAV: x.res = e.rt >>> e.rs[4:0];
                    `FN_ADDU: x.res = e.rs + e.rt;
                    `FN_SUBU: x.res = e.rs - e.rt;
                    `FN_AND:  x.res = e.rs & e.rt;
                    `FN_OR:   x.res = e.rs | e.rt;
                    `FN_XOR:  x.res = e.rs ^ e.rt;
                    `FN_NOR:  x.res = ~(e.rs | e.rt);
                    `FN_SLT:  x.res = (e.rs < e.rt) ? 1 : 0;   // Both signed
                    default:  x.ill = 1'b1;
                endcase
            end
            `OP_ADDIU: x.res = e.rs + sext;
            `OP_SLTI:  x.res = (e.rs < sext) ? 1 : 0;
            `OP_ANDI:  x.res = e.rs & zext;
            `OP_ORI:   x.res = e.rs | zext;
            `OP_XORI:  x.res = e.rs ^ zext;
            `OP_LUI:   x.res = {e.imm, 16'h0000};
            `OP_BEQ:   x.taken = (e.rs == e.rt);
            `OP_BNE:   x.taken = (e.rs != e.rt);
            default:   x.ill = 1'b1;
        endcase
        if (e.op == `OP_BEQ || e.op == `OP_BNE) begin
            x.res = x.taken ? 0 : 1;                        // Taken branch leaves zero set
        end
        x.zero = (x.res == 0);
        return x;
    endfunction

    // Drive one strobe on the falling edge and wait for the next one
    task automatic issue(input entry_t e, input bit from_model);
        expect_t x;
        if (from_model) begin
            x = model(e);
        end else begin
            x = '{e.name, e.res, e.zero, e.taken, e.ill, 0};
        end
        x.cycle   = cycle;
        i_valid   = 1'b1;
        i_opcode  = e.op;
        i_funct   = e.fn;
        i_shamt   = e.sh;
        i_imm     = e.imm;
        i_rs_data = e.rs;
        i_rt_data = e.rt;
        exp_q.push_back(x);
        @(negedge clk);
    endtask

    always @(negedge clk) begin
        expect_t x;
        if (o_valid) begin
            assert (exp_q.size() > 0) else begin
                $display("Output valid seen with no instruction in flight");
                abort_run();
            end
            x = exp_q.pop_front();
            check_value(x.name, "latency", 3, cycle - x.cycle);
            check_value(x.name, "result", x.res, o_result);
            check_value(x.name, "zero", x.zero, o_zero);
            check_value(x.name, "taken", x.taken, o_branch_taken);
            check_value(x.name, "illegal", x.ill, o_illegal);
        end else begin
            check_value("idle", "taken", 0, o_branch_taken);   // Flags only strobe with valid
            check_value("idle", "illegal", 0, o_illegal);
        end
    end

    initial begin
        int     limit;
        entry_t e;
        i_rst     = 1'b1;
        i_valid   = 1'b0;
        i_opcode  = '0;
        i_funct   = '0;
        i_shamt   = '0;
        i_imm     = '0;
        i_rs_data = '0;
        i_rt_data = '0;
        limit     = (2 * N_ENTRIES + 20) * 40;
        fork
            begin
                #(limit);
                $display("Timeout: results did not drain within %0d ns", limit);
                abort_run();
            end
        join_none
        repeat (10) @(negedge clk);
        i_rst = 1'b0;
        @(negedge clk);                                     // One idle cycle after reset
        foreach (tbl[i]) begin
            issue(tbl[i], 1'b0);
        end
        foreach (tbl[i]) begin                              // Same ops with random registers
            e      = tbl[i];
            e.name = {"rand_", tbl[i].name};
            e.rs   = $random(seed);
            e.rt   = $random(seed);
            if ((e.op == `OP_BEQ || e.op == `OP_BNE) && e.rs[0]) begin
                e.rt = e.rs;
            end
            issue(e, 1'b1);
        end
        i_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- hdl/alu.sv
`timescale 1ns/1ns

module alu (
    input  alu_pkg::reg_t       i_a,
    input  alu_pkg::reg_t       i_b,
    input  alu_pkg::alu_ctrl_e  i_alu_ctrl,
    output alu_pkg::reg_t       o_result,
    output logic                o_zero
);
    import alu_pkg::*;

    shamt_t sh;

    assign sh = i_a[4:0];                           // A already limited upstream

    always_comb begin
        case (i_alu_ctrl)
            ALU_SLL: begin
                o_result = i_b << sh;
            end
            ALU_SRL: begin
                o_result = i_b >> sh;
            end
            ALU_SRA: begin
                o_result = i_b >>> sh;              // Sign fill, i_b is signed
            end
            ALU_ADD: begin
                o_result = i_a + i_b;
            end
            ALU_SUB: begin
                o_result = i_a - i_b;
            end
            ALU_AND: begin
                o_result = i_a & i_b;
            end
            ALU_OR: begin
                o_result = i_a | i_b;
            end
            ALU_XOR: begin
                o_result = i_a ^ i_b;
            end
            ALU_NOR: begin
                o_result = ~(i_a | i_b);
            end
            ALU_SLT: begin
                o_result = reg_t'(i_a < i_b);       // Signed compare
            end
            ALU_LUI: begin
                o_result = i_b << 16;
            end
            ALU_NEQ: begin
                o_result = reg_t'(i_a != i_b);      // 0 when equal, BEQ taken
            end
            ALU_EQ: begin
                o_result = reg_t'(i_a == i_b);
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

    assign o_zero = (o_result == '0);

endmodule

//--- hdl/alu_config.svh
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

`define NB_REG          32      // Data word width
`define NB_ALU_CTRL     4       // ALU control code width

// Opcodes
`define OP_RTYPE        6'h00
`define OP_BEQ          6'h04
`define OP_BNE          6'h05
`define OP_ADDIU        6'h09
`define OP_SLTI         6'h0a
`define OP_ANDI         6'h0c
`define OP_ORI          6'h0d
`define OP_XORI         6'h0e
`define OP_LUI          6'h0f

// R-type funct codes
`define FN_SLL          6'h00
`define FN_SRL          6'h02
`define FN_SRA          6'h03
`define FN_SLLV         6'h04
`define FN_SRLV         6'h06
`define FN_SRAV         6'h07
`define FN_ADDU         6'h21
`define FN_SUBU         6'h23
`define FN_AND          6'h24
`define FN_OR           6'h25
`define FN_XOR          6'h26
`define FN_NOR          6'h27
`define FN_SLT          6'h2a

`endif

//--- hdl/alu_control.sv
`timescale 1ns/1ns
`include "alu_config.svh"

module alu_control (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_valid,
    input  alu_pkg::opcode_t    i_opcode,
    input  alu_pkg::funct_t     i_funct,
    input  alu_pkg::shamt_t     i_shamt,
    input  alu_pkg::imm_t       i_imm,
    input  alu_pkg::reg_t       i_rs_data,
    input  alu_pkg::reg_t       i_rt_data,
    decode_if.producer          o_dec
);
    import alu_pkg::*;

    alu_ctrl_e dec_ctrl;
    a_sel_e    dec_a_sel;
    b_sel_e    dec_b_sel;
    logic      dec_branch;
    logic      dec_illegal;

    always_comb begin
        dec_ctrl    = ALU_NONE;
        dec_a_sel   = A_RS;
        dec_b_sel   = B_RT;
        dec_branch  = 1'b0;
        dec_illegal = 1'b0;
        case (i_opcode)
            `OP_RTYPE: begin
                case (i_funct)
                    `FN_SLL: begin
                        dec_ctrl  = ALU_SLL;
                        dec_a_sel = A_SHAMT;
                    end
                    `FN_SRL: begin
                        dec_ctrl  = ALU_SRL;
                        dec_a_sel = A_SHAMT;
                    end
                    `FN_SRA: begin
                        dec_ctrl  = ALU_SRA;
                        dec_a_sel = A_SHAMT;
                    end
                    `FN_SLLV: begin
                        dec_ctrl  = ALU_SLL;
                        dec_a_sel = A_RS_LOW5;      // Only 5 bits of rs count
                    end
                    `FN_SRLV: begin
                        dec_ctrl  = ALU_SRL;
                        dec_a_sel = A_RS_LOW5;
                    end
                    `FN_SRAV: begin
                        dec_ctrl  = ALU_SRA;
                        dec_a_sel = A_RS_LOW5;
                    end
                    `FN_ADDU: dec_ctrl = ALU_ADD;
                    `FN_SUBU: dec_ctrl = ALU_SUB;
                    `FN_AND:  dec_ctrl = ALU_AND;
                    `FN_OR:   dec_ctrl = ALU_OR;
                    `FN_XOR:  dec_ctrl = ALU_XOR;
                    `FN_NOR:  dec_ctrl = ALU_NOR;
                    `FN_SLT:  dec_ctrl = ALU_SLT;
                    default:  dec_illegal = 1'b1;
                endcase
            end
            `OP_ADDIU: begin
                dec_ctrl  = ALU_ADD;
                dec_b_sel = B_IMM_SIGN;
            end
            `OP_SLTI: begin
                dec_ctrl  = ALU_SLT;
                dec_b_sel = B_IMM_SIGN;
            end
            `OP_ANDI: begin
                dec_ctrl  = ALU_AND;
                dec_b_sel = B_IMM_ZERO;
            end
            `OP_ORI: begin
                dec_ctrl  = ALU_OR;
                dec_b_sel = B_IMM_ZERO;
            end
            `OP_XORI: begin
                dec_ctrl  = ALU_XOR;
                dec_b_sel = B_IMM_ZERO;
            end
            `OP_LUI: begin
                dec_ctrl  = ALU_LUI;
                dec_b_sel = B_IMM_ZERO;
            end
            `OP_BEQ: begin
                dec_ctrl   = ALU_NEQ;               // Inverted so taken means zero
                dec_branch = 1'b1;
            end
            `OP_BNE: begin
                dec_ctrl   = ALU_EQ;
                dec_branch = 1'b1;
            end
            default: dec_illegal = 1'b1;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_dec.valid <= 1'b0;
        end else begin
            o_dec.valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin                          // Payload holds between strobes
            o_dec.alu_ctrl  <= dec_ctrl;
            o_dec.a_sel     <= dec_a_sel;
            o_dec.b_sel     <= dec_b_sel;
            o_dec.is_branch <= dec_branch;
            o_dec.illegal   <= dec_illegal;
            o_dec.rs_data   <= i_rs_data;
            o_dec.rt_data   <= i_rt_data;
            o_dec.shamt     <= i_shamt;
            o_dec.imm       <= i_imm;
        end
    end

    a_illegal_is_none: assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_dec.valid && o_dec.illegal |-> o_dec.alu_ctrl == ALU_NONE
    );

endmodule

//--- hdl/alu_pkg.sv
`include "alu_config.svh"

package alu_pkg;

    typedef logic signed [`NB_REG-1:0] reg_t;   // Register / ALU data word
    typedef logic [15:0]               imm_t;   // I-type immediate
    typedef logic [4:0]                shamt_t; // Shift amount
    typedef logic [5:0]                opcode_t;
    typedef logic [5:0]                funct_t;

    // Codes match the existing ALU
    typedef enum logic [`NB_ALU_CTRL-1:0] {
        ALU_SLL  = 'h0,
        ALU_SRL  = 'h1,
        ALU_SRA  = 'h2,
        ALU_ADD  = 'h3,
        ALU_SUB  = 'h4,
        ALU_AND  = 'h5,
        ALU_OR   = 'h6,
        ALU_XOR  = 'h7,
        ALU_NOR  = 'h8,
        ALU_SLT  = 'h9,
        ALU_LUI  = 'ha,
        ALU_NEQ  = 'hb,     // Used for BEQ, zero set when equal
        ALU_EQ   = 'hc,     // Used for BNE, zero set when not equal
        ALU_NONE = 'hf      // Result forced to 0
    } alu_ctrl_e;

    typedef enum logic [1:0] {
        A_RS,               // rs as is
        A_SHAMT,            // Zero-extended shamt field
        A_RS_LOW5           // Low 5 bits of rs, variable shifts
    } a_sel_e;

    typedef enum logic [1:0] {
        B_RT,
        B_IMM_SIGN,
        B_IMM_ZERO
    } b_sel_e;

endpackage

//--- hdl/decode_if.sv
`timescale 1ns/1ns

interface decode_if;
    import alu_pkg::*;

    logic      valid;       // One-cycle strobe, rest is qualified by it
    alu_ctrl_e alu_ctrl;
    a_sel_e    a_sel;
    b_sel_e    b_sel;
    logic      is_branch;
    logic      illegal;
    reg_t      rs_data;
    reg_t      rt_data;
    shamt_t    shamt;
    imm_t      imm;

    modport producer (
        output valid, alu_ctrl, a_sel, b_sel, is_branch, illegal,
        output rs_data, rt_data, shamt, imm
    );

    modport consumer (
        input  valid, alu_ctrl, a_sel, b_sel, is_branch, illegal,
        input  rs_data, rt_data, shamt, imm
    );

endinterface

//--- hdl/exec_unit.sv
`timescale 1ns/1ns

module exec_unit (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_valid,
    input  alu_pkg::opcode_t    i_opcode,
    input  alu_pkg::funct_t     i_funct,
    input  alu_pkg::shamt_t     i_shamt,
    input  alu_pkg::imm_t       i_imm,
    input  alu_pkg::reg_t       i_rs_data,
    input  alu_pkg::reg_t       i_rt_data,
    output logic                o_valid,
    output alu_pkg::reg_t       o_result,
    output logic                o_zero,
    output logic                o_branch_taken,
    output logic                o_illegal
);
    import alu_pkg::*;

    // Operand stage to execute stage
    logic      op_valid;
    alu_ctrl_e op_alu_ctrl;
    reg_t      op_a;
    reg_t      op_b;
    logic      op_is_branch;
    logic      op_illegal;

    decode_if dec_bus ();

    alu_control alu_control_i (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_valid    (i_valid),
        .i_opcode   (i_opcode),
        .i_funct    (i_funct),
        .i_shamt    (i_shamt),
        .i_imm      (i_imm),
        .i_rs_data  (i_rs_data),
        .i_rt_data  (i_rt_data),
        .o_dec      (dec_bus.producer)
    );

    operand_stage operand_stage_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_dec       (dec_bus.consumer),
        .o_valid     (op_valid),
        .o_alu_ctrl  (op_alu_ctrl),
        .o_a         (op_a),
        .o_b         (op_b),
        .o_is_branch (op_is_branch),
        .o_illegal   (op_illegal)
    );

    execute_stage execute_stage_i (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_valid        (op_valid),
        .i_alu_ctrl     (op_alu_ctrl),
        .i_a            (op_a),
        .i_b            (op_b),
        .i_is_branch    (op_is_branch),
        .i_illegal      (op_illegal),
        .o_valid        (o_valid),
        .o_result       (o_result),
        .o_zero         (o_zero),
        .o_branch_taken (o_branch_taken),
        .o_illegal      (o_illegal)
    );

endmodule

//--- hdl/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_valid,
    input  alu_pkg::alu_ctrl_e  i_alu_ctrl,
    input  alu_pkg::reg_t       i_a,
    input  alu_pkg::reg_t       i_b,
    input  logic                i_is_branch,
    input  logic                i_illegal,
    output logic                o_valid,
    output alu_pkg::reg_t       o_result,
    output logic                o_zero,
    output logic                o_branch_taken,
    output logic                o_illegal
);
    import alu_pkg::*;

    reg_t alu_result;
    logic alu_zero;

    alu alu_i (
        .i_a        (i_a),
        .i_b        (i_b),
        .i_alu_ctrl (i_alu_ctrl),
        .o_result   (alu_result),
        .o_zero     (alu_zero)
    );

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid        <= 1'b0;
            o_branch_taken <= 1'b0;
            o_illegal      <= 1'b0;
        end else begin
            o_valid        <= i_valid;
            o_branch_taken <= i_valid && i_is_branch && alu_zero;   // Strobe with valid
            o_illegal      <= i_valid && i_illegal;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_result <= alu_result;
            o_zero   <= alu_zero;
        end
    end

    a_taken_needs_valid: assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_branch_taken |-> o_valid
    );

endmodule

//--- hdl/operand_stage.sv
`timescale 1ns/1ns

module operand_stage (
    input  logic                i_clk,
    input  logic                i_rst,
    decode_if.consumer          i_dec,
    output logic                o_valid,
    output alu_pkg::alu_ctrl_e  o_alu_ctrl,
    output alu_pkg::reg_t       o_a,
    output alu_pkg::reg_t       o_b,
    output logic                o_is_branch,
    output logic                o_illegal
);
    import alu_pkg::*;

    reg_t a_next;
    reg_t b_next;

    always_comb begin
        case (i_dec.a_sel)
            A_SHAMT:   a_next = reg_t'(i_dec.shamt);            // Zero-extended
            A_RS_LOW5: a_next = reg_t'(i_dec.rs_data[4:0]);
            default:   a_next = i_dec.rs_data;
        endcase
    end

    always_comb begin
        case (i_dec.b_sel)
            B_IMM_SIGN: b_next = reg_t'(signed'(i_dec.imm));    // Sign-extended
            B_IMM_ZERO: b_next = reg_t'(i_dec.imm);
            default:    b_next = i_dec.rt_data;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_dec.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_dec.valid) begin
            o_alu_ctrl  <= i_dec.alu_ctrl;
            o_a         <= a_next;
            o_b         <= b_next;
            o_is_branch <= i_dec.is_branch;
            o_illegal   <= i_dec.illegal;
        end
    end

    // Variable shift amount must stay in range for the ALU
    a_low5_in_range: assert property (
        @(posedge i_clk) disable iff (i_rst)
        i_dec.valid && i_dec.a_sel == A_RS_LOW5 |=> o_valid && o_a < 32
    );

endmodule

//--- project.f
+incdir+hdl
hdl/alu_pkg.sv
hdl/decode_if.sv
hdl/alu.sv
hdl/alu_control.sv
hdl/operand_stage.sv
hdl/execute_stage.sv
hdl/exec_unit.sv
bench/exec_unit_tb.sv
